//--- src.f
hdl/vdp_pkg.sv
hdl/vdp_ifs.sv
hdl/vdp_regs.sv
hdl/vdp_vram.sv
hdl/vdp_timing.sv
hdl/vdp_bg_render.sv
hdl/vdp_pixel_out.sv
hdl/vdp_top.sv
dv/vdp_sva.sv
dv/vdp_tb.sv

//--- dv/vdp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_tb;
    logic       vclk = 1'b0;
    logic       reset;
    logic       io_portsel;
    logic [7:0] io_wrdata;
    logic       io_wren;
    logic       io_rddone;
    logic [7:0] io_rddata;
    logic       irq;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       vga_de;
    logic       vga_hsync;
    logic       vga_vsync;

    integer      seed = 32'ha25f5c50;
    int          cycles = 0;
    int          x_cnt = 0;      // Active pixels in the current output line
    int          line_cnt = 0;   // Active lines since vsync
    logic        check_en = 1'b0;
    logic        frame_done = 1'b0;

    // Testbench copies of the DUT state
    logic [15:0] model_vram [8192];
    logic [5:0]  model_cram [16];
    logic [7:0]  model_hscroll;
    logic [7:0]  model_vscroll;
    logic [2:0]  model_nt_base;
    logic [3:0]  model_backdrop;
    logic        model_screen_en;

    vdp_top vdp_top_inst (
        .vclk, .reset, .io_portsel, .io_wrdata, .io_wren, .io_rddone,
        .io_rddata, .irq, .vga_r, .vga_g, .vga_b, .vga_de, .vga_hsync, .vga_vsync
    );

    always #20 vclk = ~vclk;

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    ////////////////////
    // Host port
    ////////////////////
    task automatic ctrl_write(input logic [7:0] value);
        @(negedge vclk);
        io_portsel = 1'b1;
        io_wrdata  = value;
        io_wren    = 1'b1;
        @(negedge vclk);
        io_wren = 1'b0;
    endtask

    task automatic data_write(input logic [7:0] value);
        @(negedge vclk);
        io_portsel = 1'b0;
        io_wrdata  = value;
        io_wren    = 1'b1;
        @(negedge vclk);
        io_wren = 1'b0;
    endtask

    // Waits out the registered VRAM read before the strobe
    task automatic host_read(input logic sel, output logic [7:0] data);
        @(negedge vclk);
        io_portsel = sel;
        @(negedge vclk);
        @(negedge vclk);
        data      = io_rddata;
        io_rddone = 1'b1;
        @(negedge vclk);
        io_rddone = 1'b0;
    endtask

    task automatic load_address(input logic [13:0] addr, input logic [1:0] code);
        ctrl_write(addr[7:0]);
        ctrl_write({code, addr[13:8]});
    endtask

    task automatic write_register(input logic [3:0] idx, input logic [7:0] value);
        ctrl_write(value);
        ctrl_write({vdp_pkg::CODE_REG_WR, 2'b00, idx});
    endtask

    task automatic write_vram_byte(input logic [13:0] addr, input logic [7:0] value);
        data_write(value);
        if (addr[0])
            model_vram[addr[13:1]][15:8] = value;  // Odd byte is the high lane
        else
            model_vram[addr[13:1]][7:0] = value;
    endtask

    function automatic logic [7:0] vram_byte(input logic [13:0] addr);
        return addr[0] ? model_vram[addr[13:1]][15:8] : model_vram[addr[13:1]][7:0];
    endfunction

    ////////////////////
    // Reference
    ////////////////////
    function automatic int ref_pixel(input int x, input int y);
        int          row;
        int          bx;
        int          prow;
        int          bitpos;
        int          pat_idx;
        logic [15:0] name;
        logic [15:0] pat;
        logic [1:0]  c;
        logic [3:0]  ci;
        logic [5:0]  e;
        row     = (y + model_vscroll) % 256;
        bx      = (x + model_hscroll) % 256;
        name    = model_vram[model_nt_base * 1024 + (row / 8) * 32 + bx / 8];
        prow    = name[10] ? 7 - row % 8 : row % 8;  // Vflip
        pat_idx = name[8:0];
        pat     = model_vram[pat_idx * 8 + prow];
        bitpos  = name[9] ? bx % 8 : 7 - bx % 8;     // Hflip
        c       = {pat[8 + bitpos], pat[bitpos]};
        if (!model_screen_en || c == 2'b00)
            ci = model_backdrop;
        else
            ci = {1'b1, name[11], c};
        e = model_cram[ci];
        return (e[1:0] * 5) * 256 + (e[3:2] * 5) * 16 + e[5:4] * 5;
    endfunction

    // Pixel comparator samples outputs away from the rising edge
    always @(negedge vclk) begin
        if (reset || vga_vsync) begin
            x_cnt    = 0;
            line_cnt = 0;
        end else if (vga_de) begin
            if (check_en)
                check_value("vga_rgb", {vga_r, vga_g, vga_b}, ref_pixel(x_cnt, line_cnt));
            x_cnt = x_cnt + 1;
        end else if (x_cnt != 0) begin  // End of an active line
            if (check_en)
                check_value("vga_de_width", x_cnt, vdp_pkg::H_ACTIVE);
            line_cnt = line_cnt + 1;
            x_cnt    = 0;
            if (check_en && line_cnt == vdp_pkg::V_ACTIVE)
                frame_done = 1'b1;
        end
    end

    always @(posedge vclk) begin
        cycles = cycles + 1;
        if (cycles >= 5 * vdp_pkg::H_TOTAL * vdp_pkg::V_TOTAL + 20000) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            stop_with_failure();
        end
    end

    // Bound assertion failures end the run at once
    always @(vdp_top_inst.vdp_sva_inst.assert_fails) begin
        if (vdp_top_inst.vdp_sva_inst.assert_fails != 0) begin
            $display("Bound assertion failed at %0t", $time);
            stop_with_failure();
        end
    end

    task automatic sync_to_frame();
        while (!vga_vsync)
            @(negedge vclk);
        while (vga_vsync)
            @(negedge vclk);
    endtask

    task automatic check_frame();
        sync_to_frame();
        frame_done = 1'b0;
        check_en   = 1'b1;
        while (!frame_done)
            @(negedge vclk);
        check_en = 1'b0;
    endtask

    initial begin
        logic [7:0] rd;
        logic [7:0] b;
        reset      = 1'b1;
        io_portsel = 1'b0;
        io_wrdata  = 8'h00;
        io_wren    = 1'b0;
        io_rddone  = 1'b0;
        repeat (16) @(negedge vclk);
        check_value("irq", irq, 0);
        check_value("vga_de", vga_de, 0);
        check_value("vga_hsync", vga_hsync, 0);
        check_value("vga_vsync", vga_vsync, 0);
        check_value("vga_rgb", {vga_r, vga_g, vga_b}, 0);
        reset = 1'b0;
        host_read(1'b1, rd);
        check_value("status", rd, 0);

        // Lone first byte, then a status read restarts the pair
        ctrl_write(8'hff);
        host_read(1'b1, rd);
        load_address(14'h2a51, vdp_pkg::CODE_VRAM_WR);
        for (int i = 0; i < 6; i++) begin
            b = $random(seed);
            write_vram_byte(14'h2a51 + 14'(i), b);
        end
        load_address(14'h2a51, vdp_pkg::CODE_VRAM_RD);
        for (int i = 0; i < 6; i++) begin
            host_read(1'b0, rd);
            check_value("io_rddata", rd, vram_byte(14'h2a51 + 14'(i)));
        end

        ////////////////////
        // Random scene
        ////////////////////
        load_address(14'h0000, vdp_pkg::CODE_VRAM_WR);
        for (int i = 0; i < 16384; i++) begin
            b = $random(seed);
            write_vram_byte(14'(i), b);
        end
        load_address(14'h0000, vdp_pkg::CODE_CRAM_WR);
        for (int i = 0; i < 16; i++) begin
            b = $random(seed);
            data_write(b);
            model_cram[i] = b[5:0];
        end
        model_nt_base   = $random(seed);
        model_hscroll   = $random(seed);
        model_vscroll   = $random(seed);
        model_backdrop  = $random(seed);
        model_screen_en = 1'b1;
        write_register(vdp_pkg::REG_NT_BASE, {4'b0, model_nt_base, 1'b0});
        write_register(vdp_pkg::REG_HSCROLL, model_hscroll);
        write_register(vdp_pkg::REG_VSCROLL, model_vscroll);
        write_register(vdp_pkg::REG_BACKDROP, {4'b0, model_backdrop});
        write_register(vdp_pkg::REG_MODE0, 8'h00);
        write_register(vdp_pkg::REG_MODE1, 8'h60);  // Screen on, vblank irq on
        host_read(1'b1, rd);
        check_frame();

        // Vblank flag with its enable set
        while (!vga_vsync)
            @(negedge vclk);
        check_value("irq", irq, 1);
        host_read(1'b1, rd);
        check_value("status", rd, 8'h80);
        check_value("irq", irq, 0);
        host_read(1'b1, rd);
        check_value("status", rd, 0);

        // Blanked screen shows only the backdrop
        model_screen_en = 1'b0;
        model_backdrop  = $random(seed);
        write_register(vdp_pkg::REG_MODE1, 8'h00);
        write_register(vdp_pkg::REG_BACKDROP, {4'b0, model_backdrop});
        check_frame();
        while (!vga_vsync)
            @(negedge vclk);
        check_value("irq", irq, 0);
        host_read(1'b1, rd);
        check_value("status", rd, 8'h80);

        ////////////////////
        // Line interrupt
        ////////////////////
        write_register(vdp_pkg::REG_LINE_IRQ, 8'd100);
        host_read(1'b1, rd);
        write_register(vdp_pkg::REG_MODE0, 8'h10);
        check_value("irq", irq, 0);
        while (!irq)
            @(negedge vclk);
        check_value("line_cnt", line_cnt, 100);
        host_read(1'b1, rd);
        check_value("status", rd, 0);
        check_value("irq", irq, 0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/vdp_sva.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_sva (
    input wire logic       vclk,
    input wire logic       reset,
    input wire logic       io_portsel,
    input wire logic [7:0] io_wrdata,
    input wire logic       io_wren,
    input wire logic       io_rddone,
    input wire logic [3:0] vga_r,
    input wire logic [3:0] vga_g,
    input wire logic [3:0] vga_b,
    input wire logic       vga_de,
    input wire logic       vga_hsync,
    input wire logic       irq
);
    int         assert_fails = 0;  // Failed assertion count
    logic       second_byte;       // Next control write completes a pair
    logic [7:0] first_byte;
    logic       line_en_model;     // Mode0 bit 4 as written by the host
    logic       vblank_en_model;   // Mode1 bit 5

    ////////////////////
    // Host view of the enables
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            second_byte     <= 1'b0;
            first_byte      <= '0;
            line_en_model   <= 1'b0;
            vblank_en_model <= 1'b0;
        end else if (io_wren && io_portsel) begin
            second_byte <= !second_byte;
            if (!second_byte) begin
                first_byte <= io_wrdata;
            end else if (io_wrdata[7:6] == vdp_pkg::CODE_REG_WR) begin
                if (io_wrdata[3:0] == vdp_pkg::REG_MODE0)
                    line_en_model <= first_byte[4];
                if (io_wrdata[3:0] == vdp_pkg::REG_MODE1)
                    vblank_en_model <= first_byte[5];
            end
        end else if (io_wren || io_rddone) begin
            second_byte <= 1'b0;  // Data access or any read restarts the pair
        end
    end

    // Colour outputs black outside the active area
    blank_is_black: assert property (@(posedge vclk) disable iff (reset)
        !vga_de |-> (vga_r == 4'h0 && vga_g == 4'h0 && vga_b == 4'h0))
        else begin
            assert_fails++;
            $error("Colour output nonzero while vga_de is low");
        end

    de_outside_hsync: assert property (@(posedge vclk) disable iff (reset)
        !(vga_de && vga_hsync))
        else begin
            assert_fails++;
            $error("vga_de and vga_hsync high together");
        end

    irq_needs_enable: assert property (@(posedge vclk) disable iff (reset)
        $rose(irq) |-> (line_en_model || vblank_en_model))
        else begin
            assert_fails++;
            $error("irq rose with both interrupt enables clear");
        end

endmodule

bind vdp_top vdp_sva vdp_sva_inst (
    .vclk, .reset, .io_portsel, .io_wrdata, .io_wren, .io_rddone,
    .vga_r, .vga_g, .vga_b, .vga_de, .vga_hsync, .irq
);

`default_nettype wire

//--- hdl/vdp_top.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_top (
    input  logic       vclk,
    input  logic       reset,
    input  logic       io_portsel,
    input  logic [7:0] io_wrdata,
    input  logic       io_wren,
    input  logic       io_rddone,
    output logic [7:0] io_rddata,
    output logic       irq,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       vga_de,
    output logic       vga_hsync,
    output logic       vga_vsync
);
    vdp_cfg_if  cfg_if ();
    vdp_vram_if vram_if ();

    logic [8:0]  hpos;
    logic [8:0]  vpos;
    logic        de;
    logic        hsync;
    logic        vsync;
    logic        line_start;
    logic        fetch_start;
    logic [12:0] vid_addr;
    logic [15:0] vid_data;
    logic [3:0]  pix_idx;
    logic [3:0]  cram_addr;
    logic [5:0]  cram_data;
    logic        cram_wren;

    vdp_regs vdp_regs_inst (
        .vclk, .reset, .io_portsel, .io_wrdata, .io_wren, .io_rddone,
        .line_start, .vpos(vpos[7:0]), .io_rddata, .irq,
        .cram_addr, .cram_data, .cram_wren, .cfg(cfg_if), .vram(vram_if)
    );

    vdp_vram vdp_vram_inst (.vclk, .vid_addr, .vid_data, .host(vram_if));

    vdp_timing vdp_timing_inst (
        .vclk, .reset, .hpos, .vpos, .de, .hsync, .vsync, .line_start, .fetch_start
    );

    vdp_bg_render vdp_bg_render_inst (
        .vclk, .reset, .fetch_start, .vpos, .hpos, .vid_data,
        .vid_addr, .pix_idx, .cfg(cfg_if)
    );

    vdp_pixel_out vdp_pixel_out_inst (
        .vclk, .reset, .pix_idx, .de, .hsync, .vsync, .cram_addr, .cram_data, .cram_wren,
        .vga_r, .vga_g, .vga_b, .vga_de, .vga_hsync, .vga_vsync
    );

endmodule

`default_nettype wire

//--- hdl/vdp_pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_pixel_out (
    input  logic       vclk,
    input  logic       reset,
    input  logic [3:0] pix_idx,
    input  logic       de,
    input  logic       hsync,
    input  logic       vsync,
    input  logic [3:0] cram_addr,
    input  logic [5:0] cram_data,
    input  logic       cram_wren,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       vga_de,
    output logic       vga_hsync,
    output logic       vga_vsync
);
    logic [5:0] cram [16];  // b 5:4, g 3:2, r 1:0
    logic [5:0] col_q;
    logic [2:0] ctl_d1;     // de, hsync, vsync
    logic [2:0] ctl_d2;

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++)
                cram[i] <= '0;
        end else if (cram_wren) begin
            cram[cram_addr] <= cram_data;
        end
    end

    always_ff @(posedge vclk)
        col_q <= cram[pix_idx];

    ////////////////////
    // Output stage
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            ctl_d1    <= '0;
            ctl_d2    <= '0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            vga_de    <= 1'b0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
        end else begin
            ctl_d1 <= {de, hsync, vsync};
            ctl_d2 <= ctl_d1;
            vga_de    <= ctl_d2[2];
            vga_hsync <= ctl_d2[1];
            vga_vsync <= ctl_d2[0];
            if (ctl_d2[2]) begin
                vga_r <= {col_q[1:0], col_q[1:0]};
                vga_g <= {col_q[3:2], col_q[3:2]};
                vga_b <= {col_q[5:4], col_q[5:4]};
            end else begin
                vga_r <= '0;  // Black outside the active area
                vga_g <= '0;
                vga_b <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/vdp_bg_render.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_bg_render (
    input  logic        vclk,
    input  logic        reset,
    input  logic        fetch_start,
    input  logic [8:0]  vpos,
    input  logic [8:0]  hpos,
    input  logic [15:0] vid_data,
    output logic [12:0] vid_addr,
    output logic [3:0]  pix_idx,
    vdp_cfg_if.render   cfg
);
    logic        busy;
    logic [5:0]  step;       // Even name read, odd pattern read
    logic        pat_valid;  // Pattern word on vid_data
    logic [4:0]  wr_col;
    logic [7:0]  row;
    logic [7:0]  hscroll_l;
    logic [2:0]  nt_base_l;
    logic        ent_hflip;
    logic        ent_pal;
    logic [2:0]  pat_row;
    logic [8:0]  next_line;
    logic [31:0] pack_word;
    logic [31:0] linebuf [32];
    logic [7:0]  bg_x;
    logic [3:0]  nib;

    assign next_line = (vpos == 9'(vdp_pkg::V_TOTAL - 1)) ? 9'd0 : vpos + 9'd1;
    assign pat_row   = vid_data[10] ? ~row[2:0] : row[2:0];  // Vflip

    // Pattern address comes straight from the name entry just read
    assign vid_addr = step[0] ? {1'b0, vid_data[8:0], pat_row}
                              : {nt_base_l, row[7:3], step[5:1]};

    ////////////////////
    // Fetch sequencer
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            step      <= '0;
            pat_valid <= 1'b0;
            row       <= '0;
            hscroll_l <= '0;
            nt_base_l <= '0;
        end else begin
            pat_valid <= busy && step[0];
            if (fetch_start) begin
                busy      <= 1'b1;
                step      <= '0;
                row       <= next_line[7:0] + cfg.vscroll;
                hscroll_l <= cfg.hscroll;
                nt_base_l <= cfg.nt_base;
            end else if (busy) begin
                step <= step + 6'd1;
                if (step == 6'd63)
                    busy <= 1'b0;
            end
        end
    end

    // One nibble per pixel, leftmost in nibble 0
    always_comb begin
        logic [2:0] b;
        logic [1:0] c;
        pack_word = '0;
        for (int i = 0; i < 8; i++) begin
            b = ent_hflip ? 3'(i) : 3'(7 - i);
            c = {vid_data[8 + b], vid_data[b]};
            pack_word[4*i +: 4] = (c == 2'b00) ? 4'h0 : {1'b1, ent_pal, c};
        end
    end

    always_ff @(posedge vclk) begin
        if (busy && step[0]) begin
            ent_hflip <= vid_data[9];
            ent_pal   <= vid_data[11];
            wr_col    <= step[5:1];
        end
        if (pat_valid)
            linebuf[wr_col] <= pack_word;
    end

    ////////////////////
    // Scrolled readout
    ////////////////////
    assign bg_x = hpos[7:0] + hscroll_l;
    assign nib  = linebuf[bg_x[7:3]][{bg_x[2:0], 2'b00} +: 4];

    always_ff @(posedge vclk) begin
        if (!cfg.screen_en || !nib[3])
            pix_idx <= cfg.backdrop;  // Transparent or blanked
        else
            pix_idx <= nib;
    end

endmodule

`default_nettype wire

//--- hdl/vdp_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_timing (
    input  logic       vclk,
    input  logic       reset,
    output logic [8:0] hpos,
    output logic [8:0] vpos,
    output logic       de,
    output logic       hsync,
    output logic       vsync,
    output logic       line_start,
    output logic       fetch_start
);
    logic line_end;
    logic last_line;

    assign line_end  = hpos == 9'(vdp_pkg::H_TOTAL - 1);
    assign last_line = vpos == 9'(vdp_pkg::V_TOTAL - 1);

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            hpos <= '0;
            vpos <= '0;
        end else if (line_end) begin
            hpos <= '0;
            vpos <= last_line ? 9'd0 : vpos + 9'd1;
        end else begin
            hpos <= hpos + 9'd1;
        end
    end

    assign de = hpos < 9'(vdp_pkg::H_ACTIVE) && vpos < 9'(vdp_pkg::V_ACTIVE);

    assign hsync = hpos >= 9'(vdp_pkg::H_SYNC_START) && hpos < 9'(vdp_pkg::H_SYNC_END);
    assign vsync = vpos >= 9'(vdp_pkg::V_SYNC_START) && vpos < 9'(vdp_pkg::V_SYNC_END);

    assign line_start = hpos == 9'd0;

    // Fetch for the following line, first blank pixel of the line before it
    assign fetch_start = hpos == 9'(vdp_pkg::H_ACTIVE)
                         && (last_line || vpos < 9'(vdp_pkg::V_ACTIVE - 1));

endmodule

`default_nettype wire

//--- hdl/vdp_vram.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_vram (
    input  logic        vclk,
    input  logic [12:0] vid_addr,
    output logic [15:0] vid_data,
    vdp_vram_if.mem     host
);
    logic [15:0] mem [8192];
    logic [15:0] host_word;
    logic        host_hi;  // Lane of the last host read

    always_ff @(posedge vclk) begin
        if (host.wren) begin
            if (host.addr[0])
                mem[host.addr[13:1]][15:8] <= host.wrdata;
            else
                mem[host.addr[13:1]][7:0] <= host.wrdata;
        end
        host_word <= mem[host.addr[13:1]];
        host_hi   <= host.addr[0];
    end

    always_ff @(posedge vclk)
        vid_data <= mem[vid_addr];  // Video port, read only

    assign host.rddata = host_hi ? host_word[15:8] : host_word[7:0];

endmodule

`default_nettype wire

//--- hdl/vdp_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_regs (
    input  logic       vclk,
    input  logic       reset,
    input  logic       io_portsel,  // 0 data, 1 control
    input  logic [7:0] io_wrdata,
    input  logic       io_wren,
    input  logic       io_rddone,
    input  logic       line_start,
    input  logic [7:0] vpos,
    output logic [7:0] io_rddata,
    output logic       irq,
    output logic [3:0] cram_addr,
    output logic [5:0] cram_data,
    output logic       cram_wren,
    vdp_cfg_if.ctrl    cfg,
    vdp_vram_if.host   vram
);
    vdp_pkg::ctrl_byte_u cb;
    logic [1:0]  code;
    logic [13:0] addr;
    logic        toggle;       // Second control byte expected
    logic        reg_wr;
    logic        line_irq_en;
    logic        vblank_irq_en;
    logic [7:0]  line_irq_line;
    logic        vblank_pend;
    logic        line_pend;
    logic        past_active;  // Between vblank line and last line
    logic        line_hit;
    logic        ctrl_write;
    logic        data_write;
    logic        ctrl_rddone;
    logic        data_rddone;

    assign cb          = io_wrdata;
    assign ctrl_write  = io_wren && io_portsel;
    assign data_write  = io_wren && !io_portsel;
    assign ctrl_rddone = io_rddone && io_portsel;
    assign data_rddone = io_rddone && !io_portsel;
    assign reg_wr      = ctrl_write && toggle && cb.as_reg.code == vdp_pkg::CODE_REG_WR;

    // Line counter low byte aliases 0..5 after line 255
    assign line_hit = line_start && !past_active && vpos == line_irq_line
                      && line_irq_line < 8'(vdp_pkg::V_ACTIVE);

    ////////////////////
    // Address latch
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            code        <= '0;
            addr        <= '0;
            toggle      <= 1'b0;
            vblank_pend <= 1'b0;
            line_pend   <= 1'b0;
            past_active <= 1'b0;
        end else begin
            if (ctrl_write) begin
                if (!toggle) begin
                    addr[7:0] <= io_wrdata;
                end else begin
                    code       <= cb.as_addr.code;
                    addr[13:8] <= cb.as_addr.addr_hi;
                end
                toggle <= !toggle;
            end else if (data_write || data_rddone) begin
                addr   <= addr + 14'd1;  // Auto increment
                toggle <= 1'b0;
            end

            if (ctrl_rddone) begin  // Status read
                toggle      <= 1'b0;
                vblank_pend <= 1'b0;
                line_pend   <= 1'b0;
            end

            if (line_start && vpos == 8'(vdp_pkg::VBLANK_LINE)) begin
                vblank_pend <= 1'b1;
                past_active <= 1'b1;
            end else if (line_start && vpos == 8'(vdp_pkg::V_TOTAL - 1)) begin
                past_active <= 1'b0;
            end
            if (line_hit)
                line_pend <= 1'b1;
        end
    end

    ////////////////////
    // Display registers
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            line_irq_en   <= 1'b0;
            vblank_irq_en <= 1'b0;
            line_irq_line <= '0;
            cfg.screen_en <= 1'b0;
            cfg.nt_base   <= '0;
            cfg.backdrop  <= '0;
            cfg.hscroll   <= '0;
            cfg.vscroll   <= '0;
        end else if (reg_wr) begin
            // Data is the first byte, still in the address latch
            case (cb.as_reg.idx)
                vdp_pkg::REG_MODE0:    line_irq_en <= addr[4];
                vdp_pkg::REG_MODE1: begin
                    cfg.screen_en <= addr[6];
                    vblank_irq_en <= addr[5];
                end
                vdp_pkg::REG_NT_BASE:  cfg.nt_base   <= addr[3:1];
                vdp_pkg::REG_BACKDROP: cfg.backdrop  <= addr[3:0];
                vdp_pkg::REG_HSCROLL:  cfg.hscroll   <= addr[7:0];
                vdp_pkg::REG_VSCROLL:  cfg.vscroll   <= addr[7:0];
                vdp_pkg::REG_LINE_IRQ: line_irq_line <= addr[7:0];
                default: ;
            endcase
        end
    end

    assign vram.addr   = addr;
    assign vram.wrdata = io_wrdata;
    assign vram.wren   = data_write && code != vdp_pkg::CODE_CRAM_WR;

    assign cram_addr = addr[3:0];
    assign cram_data = io_wrdata[5:0];
    assign cram_wren = data_write && code == vdp_pkg::CODE_CRAM_WR;

    assign io_rddata = io_portsel ? {vblank_pend, 7'b0} : vram.rddata;
    assign irq       = (vblank_pend && vblank_irq_en) || (line_pend && line_irq_en);

endmodule

`default_nettype wire

//--- hdl/vdp_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Display settings from the register block to the video side
interface vdp_cfg_if;
    logic [7:0] hscroll;
    logic [7:0] vscroll;
    logic [2:0] nt_base;   // Word address bits 12:10
    logic [3:0] backdrop;
    logic       screen_en;

    modport ctrl   (output hscroll, vscroll, nt_base, backdrop, screen_en);
    modport render (input  hscroll, vscroll, nt_base, backdrop, screen_en);
endinterface

// Host byte port into VRAM
interface vdp_vram_if;
    logic [13:0] addr;
    logic [7:0]  wrdata;
    logic        wren;
    logic [7:0]  rddata;

    modport host (output addr, wrdata, wren, input rddata);
    modport mem  (input addr, wrdata, wren, output rddata);
endinterface

`default_nettype wire

//--- hdl/vdp_pkg.sv
`default_nettype none

package vdp_pkg;

    ////////////////////
    // Raster
    ////////////////////
    localparam int H_ACTIVE     = 256;  // Pixels
    localparam int H_TOTAL      = 342;
    localparam int H_SYNC_START = 272;
    localparam int H_SYNC_END   = 298;
    localparam int V_ACTIVE     = 192;  // Lines
    localparam int V_TOTAL      = 262;
    localparam int V_SYNC_START = 216;
    localparam int V_SYNC_END   = 219;
    localparam int VBLANK_LINE  = 192;

    // Access codes, top two bits of the second control byte
    localparam logic [1:0] CODE_VRAM_RD = 2'd0;
    localparam logic [1:0] CODE_VRAM_WR = 2'd1;
    localparam logic [1:0] CODE_REG_WR  = 2'd2;
    localparam logic [1:0] CODE_CRAM_WR = 2'd3;

    // Display register indices
    localparam logic [3:0] REG_MODE0    = 4'd0;
    localparam logic [3:0] REG_MODE1    = 4'd1;
    localparam logic [3:0] REG_NT_BASE  = 4'd2;
    localparam logic [3:0] REG_BACKDROP = 4'd7;
    localparam logic [3:0] REG_HSCROLL  = 4'd8;
    localparam logic [3:0] REG_VSCROLL  = 4'd9;
    localparam logic [3:0] REG_LINE_IRQ = 4'd10;

    typedef union packed {
        struct packed {
            logic [1:0] code;
            logic [5:0] addr_hi;  // Address bits 13:8
        } as_addr;
        struct packed {
            logic [1:0] code;
            logic [1:0] rsvd;
            logic [3:0] idx;
        } as_reg;
    } ctrl_byte_u;

endpackage

`default_nettype wire
